//--- source/frame_dma_defs.svh
`ifndef FRAME_DMA_DEFS_SVH
`define FRAME_DMA_DEFS_SVH

// frame buffers in external memory
`define BUFF_NUM        3

// beats per AXI burst, fixed on the slave side
`define BURST_LEN       4

// AXI data beat width in bits
`define DATA_W          32

// byte address width
`define ADDR_W          16

// bytes per frame buffer
`define FRAME_BYTES     64

// bytes moved by one full burst
`define BURST_BYTES     ((`DATA_W / 8) * `BURST_LEN)

// frame offset of the last burst, the address wraps after it
`define BURST_LAST_OFS  (`FRAME_BYTES - `BURST_BYTES)

`endif

//--- source/frame_dma_pkg.sv
`default_nettype none

`include "frame_dma_defs.svh"

package frame_dma_pkg;

    // byte address into external memory
    typedef logic [`ADDR_W-1:0] addr_t;

    // one AXI data beat
    typedef logic [`DATA_W-1:0] data_t;

    // frame buffer number, 0 to BUFF_NUM-1
    typedef logic [1:0] buf_idx_t;

    // beat position inside a burst
    typedef logic [7:0] beat_cnt_t;

    // write engine, one burst per trigger
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } wr_state_t;

    // read engine, one burst per trigger
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,
        RD_DATA = 2'd2
    } rd_state_t;

endpackage

`default_nettype wire

//--- source/frame_buffer_ring.sv
`default_nettype none

`include "frame_dma_defs.svh"

module frame_buffer_ring (
    input  wire                  ui_clk,
    input  wire                  Rst_INIT_DONE,
    input  wire                  wr_frame_start,
    input  wire                  rd_frame_start,
    output frame_dma_pkg::addr_t wr_base,
    output frame_dma_pkg::addr_t rd_base,
    output logic                 wr_reload,
    output logic                 rd_reload
);

    import frame_dma_pkg::*;

    // buffer the writer is filling right now
    buf_idx_t wr_cur;
    // first write frame start has been seen
    logic     wr_started;
    buf_idx_t wr_next;
    buf_idx_t rd_buf;

    // the first frame start lands on buffer 0, later ones step round the ring
    always_comb begin
        if (!wr_started || wr_cur == buf_idx_t'(`BUFF_NUM - 1)) begin
            wr_next = '0;
        end else begin
            wr_next = wr_cur + 1'b1;
        end
    end

    // reader takes the buffer written just before the current one
    assign rd_buf = (wr_cur == '0) ? buf_idx_t'(`BUFF_NUM - 1) : wr_cur - 1'b1;

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            wr_cur     <= '0;
            wr_started <= 1'b0;
            wr_base    <= '0;
        end else if (wr_frame_start) begin
            wr_cur     <= wr_next;
            wr_started <= 1'b1;
            wr_base    <= addr_t'(wr_next) * addr_t'(`FRAME_BYTES);
        end
    end

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            rd_base <= '0;
        end else if (rd_frame_start) begin
            rd_base <= addr_t'(rd_buf) * addr_t'(`FRAME_BYTES);
        end
    end

    // reload strobes line up with the cycle the new base is visible
    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            wr_reload <= 1'b0;
            rd_reload <= 1'b0;
        end else begin
            wr_reload <= wr_frame_start;
            rd_reload <= rd_frame_start;
        end
    end

    // rd_buf is derived from wr_cur, so both starts in one cycle is undefined
    a_no_coincident_starts: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        !(wr_frame_start && rd_frame_start)
    );

endmodule

`default_nettype wire

//--- source/burst_writer.sv
`default_nettype none

`include "frame_dma_defs.svh"

module burst_writer (
    input  wire                  ui_clk,
    input  wire                  Rst_INIT_DONE,
    input  wire frame_dma_pkg::addr_t wr_base,
    input  wire                  wr_reload,
    input  wire                  wr_trigger,
    output frame_dma_pkg::addr_t m_axi_awaddr,
    output logic                 m_axi_awvalid,
    input  wire                  m_axi_awready,
    output frame_dma_pkg::data_t m_axi_wdata,
    output logic                 m_axi_wlast,
    output logic                 m_axi_wvalid,
    input  wire                  m_axi_wready,
    input  wire                  m_axi_bvalid,
    output logic                 m_axi_bready,
    output logic                 wdata_fifo_rd_en,
    input  wire frame_dma_pkg::data_t wdata_fifo_rd_data
);

    import frame_dma_pkg::*;

    wr_state_t wr_state;
    beat_cnt_t beat_cnt;
    logic      aw_xfer;
    logic      w_xfer;
    addr_t     aw_ofs;

    assign aw_xfer = m_axi_awvalid && m_axi_awready;
    assign w_xfer  = m_axi_wvalid && m_axi_wready;

    // channel handshakes come straight from the state register
    assign m_axi_awvalid = (wr_state == WR_ADDR);
    assign m_axi_wvalid  = (wr_state == WR_DATA);
    assign m_axi_bready  = (wr_state == WR_RESP);

    // source FIFO is fall-through so its head word is the current beat
    assign m_axi_wdata      = wdata_fifo_rd_data;
    assign wdata_fifo_rd_en = w_xfer;
    assign m_axi_wlast      = (beat_cnt == beat_cnt_t'(`BURST_LEN - 1));

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_trigger) begin
                        wr_state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (aw_xfer) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_xfer && m_axi_wlast) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    // response code is not checked
                    if (m_axi_bvalid) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // beat counter wraps to 0 after the last beat
    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            beat_cnt <= '0;
        end else if (w_xfer) begin
            beat_cnt <= m_axi_wlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // offset inside the frame relative to the base
    assign aw_ofs = m_axi_awaddr - wr_base;

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            m_axi_awaddr <= '0;
        end else if (wr_reload) begin
            m_axi_awaddr <= wr_base;
        end else if (aw_xfer) begin
            if (aw_ofs == addr_t'(`BURST_LAST_OFS)) begin
                m_axi_awaddr <= wr_base;
            end else begin
                m_axi_awaddr <= m_axi_awaddr + addr_t'(`BURST_BYTES);
            end
        end
    end

    // frame starts must wait until the burst is fully done
    a_reload_idle: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        wr_reload |-> (wr_state == WR_IDLE)
    );

    // a stalled beat keeps valid and its FIFO head word until the slave takes it
    a_wvalid_held: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        (m_axi_wvalid && !m_axi_wready) |=> (m_axi_wvalid && $stable(m_axi_wdata))
    );

endmodule

`default_nettype wire

//--- source/burst_reader.sv
`default_nettype none

`include "frame_dma_defs.svh"

module burst_reader (
    input  wire                  ui_clk,
    input  wire                  Rst_INIT_DONE,
    input  wire frame_dma_pkg::addr_t rd_base,
    input  wire                  rd_reload,
    input  wire                  rd_trigger,
    output frame_dma_pkg::addr_t m_axi_araddr,
    output logic                 m_axi_arvalid,
    input  wire                  m_axi_arready,
    input  wire frame_dma_pkg::data_t m_axi_rdata,
    input  wire                  m_axi_rlast,
    input  wire                  m_axi_rvalid,
    output logic                 m_axi_rready,
    output logic                 rdata_fifo_wr_en,
    output frame_dma_pkg::data_t rdata_fifo_wr_data
);

    import frame_dma_pkg::*;

    rd_state_t rd_state;
    logic      ar_xfer;
    logic      r_xfer;
    addr_t     ar_ofs;

    assign ar_xfer = m_axi_arvalid && m_axi_arready;
    assign r_xfer  = m_axi_rvalid && m_axi_rready;

    assign m_axi_arvalid = (rd_state == RD_ADDR);
    assign m_axi_rready  = (rd_state == RD_DATA);

    // sink FIFO has no back-pressure, every R beat goes straight in
    assign rdata_fifo_wr_en   = r_xfer;
    assign rdata_fifo_wr_data = m_axi_rdata;

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_trigger) begin
                        rd_state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_xfer) begin
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    // slave marks the end of the burst
                    if (r_xfer && m_axi_rlast) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    assign ar_ofs = m_axi_araddr - rd_base;

    // same stepping and wrap rule as the write side
    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            m_axi_araddr <= '0;
        end else if (rd_reload) begin
            m_axi_araddr <= rd_base;
        end else if (ar_xfer) begin
            if (ar_ofs == addr_t'(`BURST_LAST_OFS)) begin
                m_axi_araddr <= rd_base;
            end else begin
                m_axi_araddr <= m_axi_araddr + addr_t'(`BURST_BYTES);
            end
        end
    end

    // no mid-burst abort, so a read frame start must find the reader idle
    a_reload_idle: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        rd_reload |-> (rd_state == RD_IDLE)
    );

endmodule

`default_nettype wire

//--- source/frame_dma_top.sv
`default_nettype none

module frame_dma_top (
    input  wire                  ui_clk,
    input  wire                  Rst_INIT_DONE,
    input  wire                  wr_frame_start,
    input  wire                  rd_frame_start,
    input  wire                  wr_trigger,
    input  wire                  rd_trigger,
    // AXI write address, data and response
    output frame_dma_pkg::addr_t m_axi_awaddr,
    output logic                 m_axi_awvalid,
    input  wire                  m_axi_awready,
    output frame_dma_pkg::data_t m_axi_wdata,
    output logic                 m_axi_wlast,
    output logic                 m_axi_wvalid,
    input  wire                  m_axi_wready,
    input  wire                  m_axi_bvalid,
    output logic                 m_axi_bready,
    // AXI read address and data
    output frame_dma_pkg::addr_t m_axi_araddr,
    output logic                 m_axi_arvalid,
    input  wire                  m_axi_arready,
    input  wire frame_dma_pkg::data_t m_axi_rdata,
    input  wire                  m_axi_rlast,
    input  wire                  m_axi_rvalid,
    output logic                 m_axi_rready,
    // source and sink FIFOs
    output logic                 wdata_fifo_rd_en,
    input  wire frame_dma_pkg::data_t wdata_fifo_rd_data,
    output logic                 rdata_fifo_wr_en,
    output frame_dma_pkg::data_t rdata_fifo_wr_data
);

    import frame_dma_pkg::*;

    addr_t wr_base;
    addr_t rd_base;
    logic  wr_reload;
    logic  rd_reload;

    frame_buffer_ring u_ring (
        .ui_clk         (ui_clk),
        .Rst_INIT_DONE  (Rst_INIT_DONE),
        .wr_frame_start (wr_frame_start),
        .rd_frame_start (rd_frame_start),
        .wr_base        (wr_base),
        .rd_base        (rd_base),
        .wr_reload      (wr_reload),
        .rd_reload      (rd_reload)
    );

    burst_writer u_writer (
        .ui_clk             (ui_clk),
        .Rst_INIT_DONE      (Rst_INIT_DONE),
        .wr_base            (wr_base),
        .wr_reload          (wr_reload),
        .wr_trigger         (wr_trigger),
        .m_axi_awaddr       (m_axi_awaddr),
        .m_axi_awvalid      (m_axi_awvalid),
        .m_axi_awready      (m_axi_awready),
        .m_axi_wdata        (m_axi_wdata),
        .m_axi_wlast        (m_axi_wlast),
        .m_axi_wvalid       (m_axi_wvalid),
        .m_axi_wready       (m_axi_wready),
        .m_axi_bvalid       (m_axi_bvalid),
        .m_axi_bready       (m_axi_bready),
        .wdata_fifo_rd_en   (wdata_fifo_rd_en),
        .wdata_fifo_rd_data (wdata_fifo_rd_data)
    );

    burst_reader u_reader (
        .ui_clk             (ui_clk),
        .Rst_INIT_DONE      (Rst_INIT_DONE),
        .rd_base            (rd_base),
        .rd_reload          (rd_reload),
        .rd_trigger         (rd_trigger),
        .m_axi_araddr       (m_axi_araddr),
        .m_axi_arvalid      (m_axi_arvalid),
        .m_axi_arready      (m_axi_arready),
        .m_axi_rdata        (m_axi_rdata),
        .m_axi_rlast        (m_axi_rlast),
        .m_axi_rvalid       (m_axi_rvalid),
        .m_axi_rready       (m_axi_rready),
        .rdata_fifo_wr_en   (rdata_fifo_wr_en),
        .rdata_fifo_wr_data (rdata_fifo_wr_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_frame_dma.sv
`default_nettype none

`include "frame_dma_defs.svh"

module tb_frame_dma;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BURSTS_PER_FRAME = `FRAME_BYTES / `BURST_BYTES;

    logic                ui_clk;
    logic                Rst_INIT_DONE;
    logic                wr_frame_start;
    logic                rd_frame_start;
    logic                wr_trigger;
    logic                rd_trigger;
    logic [`ADDR_W-1:0]  m_axi_awaddr;
    logic                m_axi_awvalid;
    logic                m_axi_awready;
    logic [`DATA_W-1:0]  m_axi_wdata;
    logic                m_axi_wlast;
    logic                m_axi_wvalid;
    logic                m_axi_wready;
    logic                m_axi_bvalid;
    logic                m_axi_bready;
    logic [`ADDR_W-1:0]  m_axi_araddr;
    logic                m_axi_arvalid;
    logic                m_axi_arready;
    logic [`DATA_W-1:0]  m_axi_rdata;
    logic                m_axi_rlast;
    logic                m_axi_rvalid;
    logic                m_axi_rready;
    logic                wdata_fifo_rd_en;
    logic [`DATA_W-1:0]  wdata_fifo_rd_data;
    logic                rdata_fifo_wr_en;
    logic [`DATA_W-1:0]  rdata_fifo_wr_data;

    // slave memory, and the words the testbench expects at each address
    logic [`DATA_W-1:0]  mem [int];
    logic [`DATA_W-1:0]  ref_mem [int];
    logic [`DATA_W-1:0]  src_q [$];
    logic [`DATA_W-1:0]  rx_q [$];
    logic [`DATA_W-1:0]  wr_words [`BURST_LEN];
    int                  aw_log [$];
    int                  ar_log [$];
    logic [7:0]          ops [$];
    logic [`DATA_W-1:0]  cmd_data [$];
    logic                nx_awready, nx_wready, nx_bvalid, nx_arready, nx_rvalid, nx_rlast;
    logic [`DATA_W-1:0]  nx_rdata;
    logic                pop_req, b_pend, r_pend, loaded, model_wr_started;
    int                  aw_wait, w_wait, b_wait, ar_wait, r_wait;
    int                  w_addr, w_beat, r_addr, r_beat, b_done, r_done;
    int                  model_wr_buf, model_wr_base, model_rd_base, model_wr_n, model_rd_n;
    int                  bursts_written, bursts_read, errors;
    int                  seed = 32'ha9be9146;

    frame_dma_top uut (.*);

    always #10 ui_clk = ~ui_clk;

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // ready or valid stall of 0 to 3 cycles
    function automatic int draw_stall();
        return $unsigned($random(seed)) % 4;
    endfunction

    // unwritten locations read back a pattern made from the address
    function automatic logic [`DATA_W-1:0] read_word(input int a);
        return mem.exists(a) ? mem[a] : {16'hbad0, a[15:0]};
    endfunction

    // slave decisions at the falling edge where DUT outputs are settled
    always @(negedge ui_clk) begin
        if (Rst_INIT_DONE) begin
            if (m_axi_awvalid && m_axi_awready) begin
                aw_log.push_back(int'(m_axi_awaddr));
                w_addr = int'(m_axi_awaddr);
                w_beat = 0;
                nx_awready = 1'b0;
                aw_wait = draw_stall();
            end else if (m_axi_awvalid) begin
                if (aw_wait == 0) nx_awready = 1'b1;
                else aw_wait--;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                if (!wdata_fifo_rd_en) report_error("W transfer without a FIFO pop");
                if (w_beat >= `BURST_LEN) begin
                    report_error("more W beats than the burst length");
                end else begin
                    if (m_axi_wdata !== wr_words[w_beat]) begin
                        report_error($sformatf("W beat %0d data %h, expected %h",
                                     w_beat, m_axi_wdata, wr_words[w_beat]));
                    end
                    if (m_axi_wlast !== (w_beat == `BURST_LEN - 1)) begin
                        report_error($sformatf("wlast %b on W beat %0d", m_axi_wlast, w_beat));
                    end
                end
                mem[w_addr + 4 * w_beat] = m_axi_wdata;
                w_beat++;
                pop_req = 1'b1;
                nx_wready = 1'b0;
                w_wait = draw_stall();
                if (m_axi_wlast) begin
                    b_pend = 1'b1;
                    b_wait = draw_stall();
                end
            end else if (m_axi_wvalid) begin
                if (w_wait == 0) nx_wready = 1'b1;
                else w_wait--;
            end else if (wdata_fifo_rd_en) begin
                report_error("FIFO pop outside a W transfer");
            end
            if (m_axi_bvalid && m_axi_bready) begin
                nx_bvalid = 1'b0;
                b_done++;
                if (w_beat != `BURST_LEN) begin
                    report_error($sformatf("burst popped %0d FIFO words", w_beat));
                end
            end else if (b_pend) begin
                if (b_wait == 0) begin
                    nx_bvalid = 1'b1;
                    b_pend = 1'b0;
                end else begin
                    b_wait--;
                end
            end
            if (m_axi_arvalid && m_axi_arready) begin
                ar_log.push_back(int'(m_axi_araddr));
                r_addr = int'(m_axi_araddr);
                r_beat = 0;
                r_pend = 1'b1;
                r_wait = draw_stall();
                nx_arready = 1'b0;
                ar_wait = draw_stall();
            end else if (m_axi_arvalid) begin
                if (ar_wait == 0) nx_arready = 1'b1;
                else ar_wait--;
            end
            if (m_axi_rvalid && m_axi_rready) begin
                r_beat++;
                nx_rvalid = 1'b0;
                if (m_axi_rlast) begin
                    r_pend = 1'b0;
                    r_done++;
                end else begin
                    r_wait = draw_stall();
                end
            end else if (r_pend && !nx_rvalid) begin
                if (r_wait == 0) begin
                    nx_rvalid = 1'b1;
                    nx_rdata = read_word(r_addr + 4 * r_beat);
                    nx_rlast = (r_beat == `BURST_LEN - 1);
                end else begin
                    r_wait--;
                end
            end
            if (rdata_fifo_wr_en) rx_q.push_back(rdata_fifo_wr_data);
        end
    end

    // slave outputs and FIFO head change 2 ns after the rising edge
    always @(posedge ui_clk) begin
        #2;
        if (pop_req) begin
            void'(src_q.pop_front());
            pop_req = 1'b0;
        end
        wdata_fifo_rd_data = (src_q.size() > 0) ? src_q[0] : '0;
        m_axi_awready = nx_awready;
        m_axi_wready  = nx_wready;
        m_axi_bvalid  = nx_bvalid;
        m_axi_arready = nx_arready;
        m_axi_rvalid  = nx_rvalid;
        m_axi_rdata   = nx_rdata;
        m_axi_rlast   = nx_rlast;
    end

    task automatic load_commands(input int fd);
        string line;
        logic [7:0] op;
        logic [`DATA_W-1:0] w0, w1, w2, w3;
        int n;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 1 || line[0] == "#" || line[0] == "\n") continue;
            w0 = '0;
            w1 = '0;
            w2 = '0;
            w3 = '0;
            n = $sscanf(line, "%c %h %h %h %h", op, w0, w1, w2, w3);
            if (op == "B" && n != 5) report_error("write burst line without four words");
            ops.push_back(op);
            cmd_data.push_back(w0);
            cmd_data.push_back(w1);
            cmd_data.push_back(w2);
            cmd_data.push_back(w3);
        end
    endtask

    task automatic check_reset_state();
        if (m_axi_awvalid || m_axi_wvalid || m_axi_bready || m_axi_arvalid || m_axi_rready) begin
            report_error("a valid or ready output is high after reset");
        end
        if (wdata_fifo_rd_en || rdata_fifo_wr_en) report_error("FIFO strobe high after reset");
        if (m_axi_awaddr !== '0 || m_axi_araddr !== '0) report_error("address not 0 after reset");
    endtask

    task automatic pulse_frame_start(input bit is_write);
        if (is_write) begin
            // the first write frame start lands on buffer 0
            model_wr_buf = model_wr_started ? (model_wr_buf + 1) % `BUFF_NUM : 0;
            model_wr_started = 1'b1;
            model_wr_base = model_wr_buf * `FRAME_BYTES;
            model_wr_n = 0;
            wr_frame_start = 1'b1;
        end else begin
            model_rd_base = ((model_wr_buf + 2) % `BUFF_NUM) * `FRAME_BYTES;
            model_rd_n = 0;
            rd_frame_start = 1'b1;
        end
        @(posedge ui_clk);
        #2;
        wr_frame_start = 1'b0;
        rd_frame_start = 1'b0;
        repeat (3) @(posedge ui_clk);
        #2;
    endtask

    // trigger held two cycles so the second one lands while the engine is busy
    task automatic write_burst(input int c);
        int exp_addr;
        int aw_before;
        int i;
        exp_addr = model_wr_base + (model_wr_n % BURSTS_PER_FRAME) * `BURST_BYTES;
        model_wr_n++;
        bursts_written++;
        aw_before = aw_log.size();
        for (i = 0; i < `BURST_LEN; i++) begin
            wr_words[i] = cmd_data[c * 4 + i];
            src_q.push_back(cmd_data[c * 4 + i]);
            ref_mem[exp_addr + 4 * i] = cmd_data[c * 4 + i];
        end
        wr_trigger = 1'b1;
        repeat (2) @(posedge ui_clk);
        #2;
        wr_trigger = 1'b0;
        wait (b_done == bursts_written);
        @(posedge ui_clk);
        #2;
        if (aw_log.size() != aw_before + 1) begin
            report_error($sformatf("%0d AW transfers for one burst", aw_log.size() - aw_before));
        end else if (aw_log[aw_before] != exp_addr) begin
            report_error($sformatf("AW address %0d, expected %0d", aw_log[aw_before], exp_addr));
        end
    endtask

    task automatic read_burst();
        int exp_addr;
        int ar_before;
        int i;
        exp_addr = model_rd_base + (model_rd_n % BURSTS_PER_FRAME) * `BURST_BYTES;
        model_rd_n++;
        bursts_read++;
        ar_before = ar_log.size();
        rx_q.delete();
        rd_trigger = 1'b1;
        repeat (2) @(posedge ui_clk);
        #2;
        rd_trigger = 1'b0;
        wait (r_done == bursts_read);
        @(posedge ui_clk);
        #2;
        if (ar_log.size() != ar_before + 1) begin
            report_error($sformatf("%0d AR transfers for one burst", ar_log.size() - ar_before));
        end else if (ar_log[ar_before] != exp_addr) begin
            report_error($sformatf("AR address %0d, expected %0d", ar_log[ar_before], exp_addr));
        end
        if (rx_q.size() != `BURST_LEN) begin
            report_error($sformatf("sink FIFO got %0d words", rx_q.size()));
        end else begin
            for (i = 0; i < `BURST_LEN; i++) begin
                if (!ref_mem.exists(exp_addr + 4 * i)
                        || rx_q[i] !== ref_mem[exp_addr + 4 * i]) begin
                    report_error($sformatf("read word %0d is %h", i, rx_q[i]));
                end
            end
        end
    endtask

    initial begin
        int fd;
        int c;
        ui_clk = 1'b0;
        Rst_INIT_DONE = 1'b0;
        wr_frame_start = 1'b0;
        rd_frame_start = 1'b0;
        wr_trigger = 1'b0;
        rd_trigger = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bvalid = 1'b0;
        m_axi_arready = 1'b0;
        m_axi_rvalid = 1'b0;
        m_axi_rdata = '0;
        m_axi_rlast = 1'b0;
        wdata_fifo_rd_data = '0;
        {nx_awready, nx_wready, nx_bvalid, nx_arready, nx_rvalid, nx_rlast} = '0;
        nx_rdata = '0;
        {pop_req, b_pend, r_pend, loaded, model_wr_started} = '0;
        fd = $fopen("testbench/frame_dma_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the command file testbench/frame_dma_input.txt");
            $display("** FAIL **");
            $finish;
        end
        load_commands(fd);
        $fclose(fd);
        loaded = 1'b1;
        repeat (4) @(posedge ui_clk);
        #2;
        Rst_INIT_DONE = 1'b1;
        @(negedge ui_clk);
        check_reset_state();
        @(posedge ui_clk);
        #2;
        for (c = 0; c < ops.size(); c++) begin
            case (ops[c])
                "W": pulse_frame_start(1'b1);
                "R": pulse_frame_start(1'b0);
                "B": write_burst(c);
                "F": read_burst();
                default: report_error($sformatf("unknown command %c", ops[c]));
            endcase
        end
        $display("run complete: %0d commands, %0d errors", ops.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog sized from the command count
    initial begin
        wait (loaded);
        repeat (ops.size() * 200 + 100) @(posedge ui_clk);
        $display("the run timed out waiting for the DUT, %0d errors so far", errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- frame_dma_top.f
+incdir+source
source/frame_dma_pkg.sv
source/frame_buffer_ring.sv
source/burst_writer.sv
source/burst_reader.sv
source/frame_dma_top.sv
testbench/tb_frame_dma.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_frame_dma
FILELIST = frame_dma_top.f
LOG      = sim.log

.PHONY: sim clean

# the log is searched for the pass line, so a failing run stops make here
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/frame_dma_input.txt
# op: W write frame start, R read frame start, B write burst, F read burst
# columns: op word0 word1 word2 word3 (hex words on B lines only)
W
B a0000000 a0000001 a0000002 a0000003
B a0000010 a0000011 a0000012 a0000013
B a0000020 a0000021 a0000022 a0000023
B a0000030 a0000031 a0000032 a0000033
B a0000040 a0000041 a0000042 a0000043
W
B b0000000 b0000001 b0000002 b0000003
R
F
F
W
B c0000000 c0000001 c0000002 c0000003
W
B d0000000 d0000001 d0000002 d0000003
